// ==== fetch_unit.f ====
rtl/fetch_pkg.sv
rtl/instruction_ram.sv
rtl/instruction_mem.sv
rtl/pc_counter.sv
rtl/fetch_control.sv
rtl/instruction_decode.sv
rtl/fetch_unit.sv
dv/fetch_unit_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := fetch_unit_tb
FILELIST := fetch_unit.f
OBJ_DIR  := obj_dir
PASS_MSG := ALL TESTS PASSED

.PHONY: sim clean

# The run passes only if the pass message shows up in the simulator output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;
    import fetch_pkg::*;

    localparam int MEM_DEPTH   = 128;
    localparam int PROG_LEN    = 40;
    localparam int WAIT_LIMIT  = 1000;
    localparam int QUIET_TIME  = 20;
    localparam logic [WORD-1:0] HALT_PC = WORD'(2 * (PROG_LEN - 1));
    localparam logic [WORD-1:0] JUMP_PC = WORD'(16);

    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
        logic [7:0] imm;
    } fields_t;

    logic                 clk_i;
    logic                 reset_i;
    logic                 start_i;
    logic                 stall_i;
    logic                 redirect_i;
    logic [WORD-1:0]      redirect_pc_i;
    logic                 prog_we_i;
    logic [WORD-1:0]      prog_addr_i;
    logic [HALF_WORD-1:0] prog_data_i;
    logic                 valid_o;
    logic [WORD-1:0]      pc_o;
    opcode_t              opcode_o;
    logic [3:0]           rd_o;
    logic [3:0]           rs1_o;
    logic [3:0]           rs2_o;
    logic [7:0]           imm_o;
    logic                 halted_o;

    logic [HALF_WORD-1:0] prog [PROG_LEN];
    logic [31:0]          rng_state = 32'h11a1;
    logic                 started;
    string                test_name;
    int                   value_errors = 0;
    int                   other_errors = 0;
    int                   issue_count;
    logic [WORD-1:0]      expected_pc;
    logic [WORD-1:0]      last_pc;
    opcode_t              last_opcode;
    int                   count_at_jump;

    fetch_unit #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_fetch_unit (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .start_i       (start_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .prog_we_i     (prog_we_i),
        .prog_addr_i   (prog_addr_i),
        .prog_data_i   (prog_data_i),
        .valid_o       (valid_o),
        .pc_o          (pc_o),
        .opcode_o      (opcode_o),
        .rd_o          (rd_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .imm_o         (imm_o),
        .halted_o      (halted_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Opcodes 8 to 14 carry an immediate and all others three registers
    function automatic fields_t expected_fields(input instr_t word);
        fields_t f;
        f = '0;
        f.opcode = word.r_form.opcode;
        if (word.r_form.opcode inside {[4'd8:4'd14]}) begin
            f.rd  = word.i_form.rd;
            f.imm = word.i_form.imm;
        end else begin
            f.rd  = word.r_form.rd;
            f.rs1 = word.r_form.rs1;
            f.rs2 = word.r_form.rs2;
        end
        return f;
    endfunction

    task automatic check_pc(input string name, input logic [WORD-1:0] exp_pc,
                            input logic [WORD-1:0] act_pc);
        if (act_pc !== exp_pc) begin
            value_errors++;
            $display("CHECK FAILED [%s] pc: expected %h, actual %h", name, exp_pc, act_pc);
        end
    endtask

    task automatic check_opcode(input string name, input opcode_t exp_op, input opcode_t act_op);
        if (act_op !== exp_op) begin
            value_errors++;
            $display("CHECK FAILED [%s] opcode: expected %h, actual %h", name, exp_op, act_op);
        end
    endtask

    task automatic check_fields(input string name, input fields_t exp_f, input logic [3:0] rd,
                                input logic [3:0] rs1, input logic [3:0] rs2,
                                input logic [7:0] imm);
        if ({rd, rs1, rs2, imm} !== {exp_f.rd, exp_f.rs1, exp_f.rs2, exp_f.imm}) begin
            value_errors++;
            $write("CHECK FAILED [%s] fields: expected rd=%h rs1=%h rs2=%h imm=%h,",
                   name, exp_f.rd, exp_f.rs1, exp_f.rs2, exp_f.imm);
            $display(" actual rd=%h rs1=%h rs2=%h imm=%h", rd, rs1, rs2, imm);
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (act_n != exp_n) begin
            value_errors++;
            $display("CHECK FAILED [%s] issue count: expected %0d, actual %0d", name, exp_n, act_n);
        end
    endtask

    // Every issued instruction is checked against the program at the expected pc
    always @(posedge clk_i) begin : compare_issue
        fields_t exp_f;
        int      idx;
        if (reset_i) begin
            expected_pc = '0;
            issue_count = 0;
            last_pc     = '0;
            last_opcode = '0;
        end else begin
            if (valid_o && !started) begin
                other_errors++;
                $display("ERROR [%s]: valid_o went high before start_i", test_name);
            end
            if (valid_o && halted_o) begin
                other_errors++;
                $display("ERROR [%s]: valid_o went high after halted_o", test_name);
            end
            if (valid_o && !stall_i && started) begin
                idx = int'(expected_pc >> 1);
                if (idx < PROG_LEN) begin
                    exp_f = expected_fields(instr_t'(prog[idx]));
                    check_pc(test_name, expected_pc, pc_o);
                    check_opcode(test_name, exp_f.opcode, opcode_o);
                    check_fields(test_name, exp_f, rd_o, rs1_o, rs2_o, imm_o);
                end else begin
                    other_errors++;
                    $display("ERROR [%s]: instruction issued past the end of the program",
                             test_name);
                end
                issue_count++;
                last_pc     = pc_o;
                last_opcode = opcode_o;
                expected_pc = expected_pc + WORD'(2);
            end
            if (redirect_i) begin
                expected_pc = redirect_pc_i;
            end
        end
    end

    task automatic build_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            rng_state = xorshift(rng_state);
            prog[i] = rng_state[15:0];
            if (prog[i][15:12] == OP_HALT) begin
                prog[i][15:12] = 4'd7;
            end
        end
        // Make sure both instruction forms appear
        prog[0][15:12] = 4'd2;
        prog[1][15:12] = 4'd10;
        prog[PROG_LEN-1][15:12] = OP_HALT;
    endtask

    task automatic apply_reset();
        @(negedge clk_i);
        reset_i = 1'b1;
        started = 1'b0;
        stall_i = 1'b0;
        repeat (10) @(negedge clk_i);
        reset_i = 1'b0;
        if (valid_o || halted_o) begin
            other_errors++;
            $display("ERROR [%s]: valid_o or halted_o high after reset", test_name);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk_i);
            prog_we_i   = 1'b1;
            prog_addr_i = WORD'(2 * i);
            prog_data_i = prog[i];
        end
        @(negedge clk_i);
        prog_we_i = 1'b0;
    endtask

    task automatic drive_cycle(input bit random_stall);
        @(negedge clk_i);
        if (random_stall) begin
            rng_state = xorshift(rng_state);
            stall_i   = (rng_state[2:0] < 3'd3);
        end else begin
            stall_i = 1'b0;
        end
    endtask

    task automatic start_pulse();
        @(negedge clk_i);
        start_i = 1'b1;
        started = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
    endtask

    task automatic wait_issues(input int target, input bit random_stall);
        int n;
        for (n = 0; n < WAIT_LIMIT && issue_count < target; n++) begin
            drive_cycle(random_stall);
        end
        if (issue_count < target) begin
            other_errors++;
            $display("ERROR [%s]: timed out waiting for %0d issued instructions",
                     test_name, target);
        end
    endtask

    // Waits for halt, then watches a quiet period and checks the last issue
    task automatic finish_run(input bit random_stall, input int exp_count);
        int n;
        for (n = 0; n < WAIT_LIMIT && !halted_o; n++) begin
            drive_cycle(random_stall);
        end
        stall_i = 1'b0;
        if (!halted_o) begin
            other_errors++;
            $display("ERROR [%s]: timed out waiting for halted_o", test_name);
        end
        repeat (QUIET_TIME) drive_cycle(1'b0);
        if (!halted_o) begin
            other_errors++;
            $display("ERROR [%s]: halted_o dropped before reset", test_name);
        end
        check_pc(test_name, HALT_PC, last_pc);
        check_opcode(test_name, OP_HALT, last_opcode);
        check_count(test_name, exp_count, issue_count);
    endtask

    initial begin
        reset_i       = 1'b1;
        start_i       = 1'b0;
        stall_i       = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        prog_we_i     = 1'b0;
        prog_addr_i   = '0;
        prog_data_i   = '0;
        started       = 1'b0;
        test_name     = "reset";
        build_program();
        apply_reset();

        test_name = "in_order";
        load_program();
        start_pulse();
        finish_run(1'b0, PROG_LEN);

        test_name = "stall";
        apply_reset();
        start_pulse();
        finish_run(1'b1, PROG_LEN);

        // Jump back to an earlier pc partway through the run
        test_name = "redirect";
        apply_reset();
        start_pulse();
        wait_issues(12, 1'b1);
        @(negedge clk_i);
        redirect_i    = 1'b1;
        redirect_pc_i = JUMP_PC;
        @(negedge clk_i);
        redirect_i    = 1'b0;
        count_at_jump = issue_count;
        finish_run(1'b1, count_at_jump + PROG_LEN - int'(JUMP_PC >> 1));

        $display("Error counts: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int MEM_DEPTH = 512
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            start_i,
    input  logic                            stall_i,
    input  logic                            redirect_i,
    input  logic [fetch_pkg::WORD-1:0]      redirect_pc_i,
    input  logic                            prog_we_i,
    input  logic [fetch_pkg::WORD-1:0]      prog_addr_i,
    input  logic [fetch_pkg::HALF_WORD-1:0] prog_data_i,
    output logic                            valid_o,
    output logic [fetch_pkg::WORD-1:0]      pc_o,
    output fetch_pkg::opcode_t              opcode_o,
    output logic [3:0]                      rd_o,
    output logic [3:0]                      rs1_o,
    output logic [3:0]                      rs2_o,
    output logic [7:0]                      imm_o,
    output logic                            halted_o
);
    import fetch_pkg::*;

    logic                 pc_clear;
    logic                 pc_step;
    logic                 pc_load;
    logic                 fetch_valid;
    logic                 mem_write;
    logic                 halt_seen;
    stall_pipeline_sig    stall;
    flush_pipeline_sig    flush;
    logic [WORD-1:0]      fetch_addr;
    logic [WORD-1:0]      mem_addr;
    logic                 mem_valid;
    logic [WORD-1:0]      mem_pc;
    logic [HALF_WORD-1:0] mem_instr;

    // Host writes share the single RAM address port while idle
    assign mem_addr = mem_write ? prog_addr_i : fetch_addr;

    fetch_control u_fetch_control (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .start_i       (start_i),
        .stall_i       (stall_i),
        .redirect_i    (redirect_i),
        .prog_we_i     (prog_we_i),
        .halt_i        (halt_seen),
        .pc_clear_o    (pc_clear),
        .pc_step_o     (pc_step),
        .pc_load_o     (pc_load),
        .fetch_valid_o (fetch_valid),
        .mem_write_o   (mem_write),
        .halted_o      (halted_o),
        .stall_o       (stall),
        .flush_o       (flush)
    );

    pc_counter u_pc_counter (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .clear_i   (pc_clear),
        .step_i    (pc_step),
        .load_i    (pc_load),
        .load_pc_i (redirect_pc_i),
        .pc_o      (fetch_addr)
    );

    instruction_mem #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_instruction_mem (
        .clk_i                  (clk_i),
        .reset_i                (reset_i),
        .program_mem_write_en_i (mem_write),
        .is_valid_i             (fetch_valid),
        .flush_pipeline_i       (flush),
        .stall_pipeline_i       (stall),
        .instruction_i          (prog_data_i),
        .instruction_addr_i     (mem_addr),
        .is_valid_o             (mem_valid),
        .instruction_o          (mem_instr),
        .program_counter_o      (mem_pc)
    );

    instruction_decode u_instruction_decode (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .valid_i  (mem_valid),
        .stall_i  (stall),
        .flush_i  (flush),
        .instr_i  (mem_instr),
        .pc_i     (mem_pc),
        .valid_o  (valid_o),
        .halt_o   (halt_seen),
        .pc_o     (pc_o),
        .opcode_o (opcode_o),
        .rd_o     (rd_o),
        .rs1_o    (rs1_o),
        .rs2_o    (rs2_o),
        .imm_o    (imm_o)
    );

endmodule

`default_nettype wire

// ==== rtl/instruction_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         valid_i,
    input  fetch_pkg::stall_pipeline_sig stall_i,
    input  fetch_pkg::flush_pipeline_sig flush_i,
    input  fetch_pkg::instr_t            instr_i,
    input  logic [fetch_pkg::WORD-1:0]   pc_i,
    output logic                         valid_o,
    output logic                         halt_o,
    output logic [fetch_pkg::WORD-1:0]   pc_o,
    output fetch_pkg::opcode_t           opcode_o,
    output logic [3:0]                   rd_o,
    output logic [3:0]                   rs1_o,
    output logic [3:0]                   rs2_o,
    output logic [7:0]                   imm_o
);
    import fetch_pkg::*;

    logic is_i_form;

    // Opcodes 8..14 carry an immediate
    assign is_i_form = (instr_i.r_form.opcode >= 4'd8) && (instr_i.r_form.opcode <= 4'd14);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (flush_i == FLUSH_PIPELINE) begin
            valid_o <= 1'b0;
        end else if (stall_i == RUN_PIPELINE) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (stall_i == RUN_PIPELINE) begin
            pc_o     <= pc_i;
            opcode_o <= instr_i.r_form.opcode;
            if (is_i_form) begin
                rd_o  <= instr_i.i_form.rd;
                rs1_o <= '0;
                rs2_o <= '0;
                imm_o <= instr_i.i_form.imm;
            end else begin
                rd_o  <= instr_i.r_form.rd;
                rs1_o <= instr_i.r_form.rs1;
                rs2_o <= instr_i.r_form.rs2;
                imm_o <= '0;
            end
        end
    end

    assign halt_o = valid_o && (opcode_o == OP_HALT);

    // An issued HALT is the last valid instruction; control flushes behind it
    assert property (@(posedge clk_i) disable iff (reset_i)
        (halt_o && stall_i == RUN_PIPELINE) |=> !valid_o);

endmodule

`default_nettype wire

// ==== rtl/fetch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         start_i,
    input  logic                         stall_i,
    input  logic                         redirect_i,
    input  logic                         prog_we_i,
    input  logic                         halt_i,
    output logic                         pc_clear_o,
    output logic                         pc_step_o,
    output logic                         pc_load_o,
    output logic                         fetch_valid_o,
    output logic                         mem_write_o,
    output logic                         halted_o,
    output fetch_pkg::stall_pipeline_sig stall_o,
    output fetch_pkg::flush_pipeline_sig flush_o
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        HALTED = 2'd2
    } state_t;

    state_t state;
    state_t state_next;
    logic   running;
    logic   halt_take;

    assign running = (state == RUN);

    // HALT counts only when it leaves decode without a stall
    assign halt_take = running && halt_i && !stall_i;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start_i) begin
                    state_next = RUN;
                end
            end
            RUN: begin
                if (halt_take) begin
                    state_next = HALTED;
                end
            end
            default: begin
                state_next = HALTED;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign pc_clear_o    = (state == IDLE);
    assign pc_step_o     = running && !stall_i;
    assign pc_load_o     = running && redirect_i;
    assign mem_write_o   = (state == IDLE) && prog_we_i;
    assign halted_o      = (state == HALTED);
    assign stall_o       = (running && stall_i) ? STALL_PIPELINE : RUN_PIPELINE;
    assign flush_o       = (redirect_i || halt_take) ? FLUSH_PIPELINE : KEEP_PIPELINE;
    assign fetch_valid_o = running && (flush_o == KEEP_PIPELINE);

    // A HALT reaches decode only while the machine runs
    assert property (@(posedge clk_i) disable iff (reset_i)
        halt_i |-> running);

    // Halted is left only through reset
    assert property (@(posedge clk_i) disable iff (reset_i)
        halted_o |=> halted_o);

endmodule

`default_nettype wire

// ==== rtl/pc_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       clear_i,
    input  logic                       step_i,
    input  logic                       load_i,
    input  logic [fetch_pkg::WORD-1:0] load_pc_i,
    output logic [fetch_pkg::WORD-1:0] pc_o
);
    import fetch_pkg::*;

    localparam logic [WORD-1:0] PC_STEP = WORD'(2);

    // Redirect wins over a plain step
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            pc_o <= '0;
        end else if (load_i) begin
            pc_o <= load_pc_i;
        end else if (step_i) begin
            pc_o <= pc_o + PC_STEP;
        end
    end

    // Instructions are halfword aligned, including redirect targets from outside
    assert property (@(posedge clk_i) disable iff (reset_i)
        !pc_o[0]);

endmodule

`default_nettype wire

// ==== rtl/instruction_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_mem #(
    parameter int MEM_DEPTH = 512
) (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            program_mem_write_en_i,
    input  logic                            is_valid_i,
    input  fetch_pkg::flush_pipeline_sig    flush_pipeline_i,
    input  fetch_pkg::stall_pipeline_sig    stall_pipeline_i,
    input  logic [fetch_pkg::HALF_WORD-1:0] instruction_i,
    input  logic [fetch_pkg::WORD-1:0]      instruction_addr_i,
    output logic                            is_valid_o,
    output logic [fetch_pkg::HALF_WORD-1:0] instruction_o,
    output logic [fetch_pkg::WORD-1:0]      program_counter_o
);
    import fetch_pkg::*;

    logic [WORD-1:0] next_instruction_addr;

    // Under stall the slot re-reads its own address so the RAM output stays put
    always_comb begin
        if (stall_pipeline_i == STALL_PIPELINE) begin
            next_instruction_addr = program_counter_o;
        end else begin
            next_instruction_addr = instruction_addr_i;
        end
    end

    instruction_ram #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_instruction_ram (
        .clk_i              (clk_i),
        .write_en_i         (program_mem_write_en_i),
        .instruction_addr_i (next_instruction_addr),
        .data_i             (instruction_i),
        .instruction_o      (instruction_o)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            is_valid_o        <= 1'b0;
            program_counter_o <= '0;
        end else begin
            if (flush_pipeline_i == FLUSH_PIPELINE) begin
                is_valid_o <= 1'b0;
            end else if (stall_pipeline_i == RUN_PIPELINE) begin
                is_valid_o <= is_valid_i;
            end
            program_counter_o <= next_instruction_addr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/instruction_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_ram #(
    parameter int MEM_DEPTH = 512
) (
    input  logic                            clk_i,
    input  logic                            write_en_i,
    input  logic [fetch_pkg::WORD-1:0]      instruction_addr_i,
    input  logic [fetch_pkg::HALF_WORD-1:0] data_i,
    output logic [fetch_pkg::HALF_WORD-1:0] instruction_o
);
    import fetch_pkg::*;

    localparam int INDEX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [HALF_WORD-1:0] mem [MEM_DEPTH];
    logic [INDEX_W-1:0]   index;

    // Byte address to halfword slot, wrapped into the array
    assign index = INDEX_W'((instruction_addr_i >> 1) % WORD'(MEM_DEPTH));

    always_ff @(posedge clk_i) begin
        if (write_en_i) begin
            mem[index] <= data_i;
        end
        instruction_o <= mem[index];
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    localparam int WORD      = 32;
    localparam int HALF_WORD = 16;

    typedef enum logic {
        RUN_PIPELINE   = 1'b0,
        STALL_PIPELINE = 1'b1
    } stall_pipeline_sig;

    typedef enum logic {
        KEEP_PIPELINE  = 1'b0,
        FLUSH_PIPELINE = 1'b1
    } flush_pipeline_sig;

    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_HALT = 4'd15;

    // Register form, also used by HALT
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] rs2;
    } r_form_t;

    // Immediate form, opcodes 8 to 14
    typedef struct packed {
        opcode_t    opcode;
        logic [3:0] rd;
        logic [7:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_t;

endpackage

`default_nettype wire
